/* build.f */
+incdir+.
osc_pkg.sv
osc_sys_regs.sv
osc_capture_mux.sv
osc_osd_overlay.sv
osc_resync_led.sv
osc_top.sv
osc_tb.sv

/* osc_capture_mux.sv */
// ------------------------------------------------
// Capture stage for the analog and HDMI sources
// Analog is 2 cycles to the output, HDMI is 3
// ------------------------------------------------
`timescale 1ns/1ps
`include "osc_defs.svh"

module osc_capture_mux (
    input  logic                  pclk_out,
    input  logic                  po_reset_n,
    input  logic                  capture_sel_i,
    input  logic                  hsync_pol_i,
    input  logic                  vsync_pol_i,
    input  logic [`OSC_PIX_W-1:0] ana_r_i,
    input  logic [`OSC_PIX_W-1:0] ana_g_i,
    input  logic [`OSC_PIX_W-1:0] ana_b_i,
    input  logic                  ana_hsync_i,
    input  logic                  ana_vsync_i,
    input  logic                  ana_de_i,
    input  logic [`OSC_PIX_W-1:0] hdmi_r_i,
    input  logic [`OSC_PIX_W-1:0] hdmi_g_i,
    input  logic [`OSC_PIX_W-1:0] hdmi_b_i,
    input  logic                  hdmi_hsync_i,
    input  logic                  hdmi_vsync_i,
    input  logic                  hdmi_de_i,
    output logic [`OSC_PIX_W-1:0] cap_r_o,
    output logic [`OSC_PIX_W-1:0] cap_g_o,
    output logic [`OSC_PIX_W-1:0] cap_b_o,
    output logic                  cap_hsync_o,
    output logic                  cap_vsync_o,
    output logic                  cap_de_o
);

    // Packed as {r, g, b, hsync, vsync, de}
    logic [`OSC_VID_W-1:0] ana_q;
    logic [`OSC_VID_W-1:0] ana_fix;
    logic [`OSC_VID_W-1:0] hdmi_q1;
    logic [`OSC_VID_W-1:0] hdmi_q2;
    logic [`OSC_VID_W-1:0] cap_q;

    always_ff @(posedge pclk_out or negedge po_reset_n) begin
        if (!po_reset_n) begin
            ana_q   <= '0;
            hdmi_q1 <= '0;
            hdmi_q2 <= '0;
        end else begin
            ana_q   <= {ana_r_i, ana_g_i, ana_b_i, ana_hsync_i, ana_vsync_i, ana_de_i};
            hdmi_q1 <= {hdmi_r_i, hdmi_g_i, hdmi_b_i, hdmi_hsync_i, hdmi_vsync_i, hdmi_de_i};
            hdmi_q2 <= hdmi_q1;
        end
    end

    // Digitizer syncs may arrive active high
    assign ana_fix = {ana_q[`OSC_VID_W-1:3],
                      ana_q[2] ^ hsync_pol_i,
                      ana_q[1] ^ vsync_pol_i,
                      ana_q[0]};

    always_ff @(posedge pclk_out or negedge po_reset_n) begin
        if (!po_reset_n) begin
            cap_q <= '0;
        end else begin
            cap_q <= capture_sel_i ? hdmi_q2 : ana_fix;
        end
    end

    assign {cap_r_o, cap_g_o, cap_b_o, cap_hsync_o, cap_vsync_o, cap_de_o} = cap_q;

endmodule

/* osc_defs.svh */
// ------------------------------------------------
// Shared constants for the scan converter output path
// Include wherever widths, addresses or OSD colors are needed
// ------------------------------------------------
`ifndef OSC_DEFS_SVH
`define OSC_DEFS_SVH

// Video and bus widths
`define OSC_PIX_W 8
`define OSC_VID_W (3 * `OSC_PIX_W + 3)
`define OSC_BTN_W 6
`define OSC_ADDR_W 4
`define OSC_DATA_W 32
`define OSC_CTRL_W 5

// Register map
`define OSC_REG_CTRL 0
`define OSC_REG_STATUS 4
`define OSC_STAT_RESYNC_BIT 8

// OSD palette, RGB
`define OSC_COLOR_BLACK 24'h000000
`define OSC_COLOR_BLUE 24'h0000ff
`define OSC_COLOR_YELLOW 24'hffff00
`define OSC_COLOR_WHITE 24'hffffff

// Resync LED hold, kept short
`define OSC_RESYNC_LED_CYCLES 64
`define OSC_RESYNC_CTR_W ($clog2(`OSC_RESYNC_LED_CYCLES + 1))

`endif

/* osc_osd_overlay.sv */
// ------------------------------------------------
// OSD color overlay and output register to the HDMI TX
// Adds 2 cycles; OSD inputs align with the video input
// ------------------------------------------------
`timescale 1ns/1ps
`include "osc_defs.svh"

module osc_osd_overlay (
    input  logic                  pclk_out,
    input  logic                  po_reset_n,
    input  logic [`OSC_PIX_W-1:0] r_i,
    input  logic [`OSC_PIX_W-1:0] g_i,
    input  logic [`OSC_PIX_W-1:0] b_i,
    input  logic                  hsync_i,
    input  logic                  vsync_i,
    input  logic                  de_i,
    input  logic                  osd_enable_i,
    input  osc_pkg::osd_color_e   osd_color_i,
    output logic [`OSC_PIX_W-1:0] tx_r_o,
    output logic [`OSC_PIX_W-1:0] tx_g_o,
    output logic [`OSC_PIX_W-1:0] tx_b_o,
    output logic                  tx_hsync_o,
    output logic                  tx_vsync_o,
    output logic                  tx_de_o
);

    logic [3*`OSC_PIX_W-1:0] osd_rgb;
    logic [3*`OSC_PIX_W-1:0] pix_q;
    logic [2:0]              sync_q;

    always_comb begin
        case (osd_color_i)
            osc_pkg::OSD_BLACK:  osd_rgb = `OSC_COLOR_BLACK;
            osc_pkg::OSD_BLUE:   osd_rgb = `OSC_COLOR_BLUE;
            osc_pkg::OSD_YELLOW: osd_rgb = `OSC_COLOR_YELLOW;
            osc_pkg::OSD_WHITE:  osd_rgb = `OSC_COLOR_WHITE;
        endcase
    end

    // Stage 1, pixel substitution
    always_ff @(posedge pclk_out or negedge po_reset_n) begin
        if (!po_reset_n) begin
            pix_q  <= '0;
            sync_q <= '0;
        end else begin
            pix_q  <= osd_enable_i ? osd_rgb : {r_i, g_i, b_i};
            sync_q <= {hsync_i, vsync_i, de_i};
        end
    end

    // Stage 2, output register
    always_ff @(posedge pclk_out or negedge po_reset_n) begin
        if (!po_reset_n) begin
            {tx_r_o, tx_g_o, tx_b_o} <= '0;
            {tx_hsync_o, tx_vsync_o, tx_de_o} <= '0;
        end else begin
            {tx_r_o, tx_g_o, tx_b_o} <= pix_q;
            {tx_hsync_o, tx_vsync_o, tx_de_o} <= sync_q;
        end
    end

    // Pipeline must stay defined from reset onward
    a_tx_de_known: assert property (
        @(posedge pclk_out) disable iff (!po_reset_n)
        !$isunknown(tx_de_o)
    );

endmodule

/* osc_pkg.sv */
// ------------------------------------------------
// Types shared by the output path modules
// Referenced by scoped name, e.g. osc_pkg::REG_CTRL
// ------------------------------------------------
`include "osc_defs.svh"

package osc_pkg;

    // APB register addresses
    typedef enum logic [`OSC_ADDR_W-1:0] {
        REG_CTRL   = `OSC_REG_CTRL,
        REG_STATUS = `OSC_REG_STATUS
    } reg_addr_e;

    // OSD color codes from the OSD generator
    typedef enum logic [1:0] {
        OSD_BLACK,
        OSD_BLUE,
        OSD_YELLOW,
        OSD_WHITE
    } osd_color_e;

    // Bit positions in the control register
    typedef enum logic [2:0] {
        CTRL_POWERON,
        CTRL_CAPTURE_SEL,
        CTRL_HSYNC_POL,
        CTRL_VSYNC_POL,
        CTRL_FRAMELOCK
    } ctrl_bit_e;

endpackage

/* osc_resync_led.sv */
// ------------------------------------------------
// Resync indicator LED with standby blink
// Strobe is synchronized, edge detected and held on a counter
// ------------------------------------------------
`timescale 1ns/1ps
`include "osc_defs.svh"

module osc_resync_led (
    input  logic       pclk_out,
    input  logic       po_reset_n,
    input  logic       resync_strobe_i,
    input  logic       poweron_i,
    input  logic       framelock_i,
    output logic [1:0] led_o,
    output logic       resync_active_o
);

    logic                         strobe_sync1_q;
    logic                         strobe_sync2_q;
    logic                         strobe_prev_q;
    logic                         strobe_rise;
    logic [`OSC_RESYNC_CTR_W-1:0] ctr_q;

    always_ff @(posedge pclk_out or negedge po_reset_n) begin
        if (!po_reset_n) begin
            strobe_sync1_q <= 1'b0;
            strobe_sync2_q <= 1'b0;
            strobe_prev_q  <= 1'b0;
        end else begin
            strobe_sync1_q <= resync_strobe_i;
            strobe_sync2_q <= strobe_sync1_q;
            strobe_prev_q  <= strobe_sync2_q;
        end
    end

    assign strobe_rise = strobe_sync2_q & ~strobe_prev_q;

    always_ff @(posedge pclk_out or negedge po_reset_n) begin
        if (!po_reset_n) begin
            ctr_q <= '0;
        end else if (poweron_i) begin
            if (strobe_rise) begin
                ctr_q <= `OSC_RESYNC_LED_CYCLES;
            end else if (ctr_q > `OSC_RESYNC_LED_CYCLES) begin
                // leftover blink count from standby
                ctr_q <= '0;
            end else if (ctr_q != '0) begin
                ctr_q <= ctr_q - 1'b1;
            end
        end else begin
            ctr_q <= ctr_q - 1'b1;
        end
    end

    assign resync_active_o = poweron_i & (ctr_q != '0);
    assign led_o[0] = poweron_i ? (ctr_q != '0) : ~ctr_q[`OSC_RESYNC_CTR_W-1];
    assign led_o[1] = poweron_i & framelock_i;

    // Once powered on, the hold count stays within one LED period
    a_ctr_bounded: assert property (
        @(posedge pclk_out) disable iff (!po_reset_n)
        poweron_i && $past(poweron_i) |-> ctr_q <= `OSC_RESYNC_LED_CYCLES
    );

endmodule

/* osc_sys_regs.sv */
// ------------------------------------------------
// APB register block for system control and status
// Control bits fan out as single wires, buttons are synchronized
// ------------------------------------------------
`timescale 1ns/1ps
`include "osc_defs.svh"

module osc_sys_regs (
    input  logic                   pclk_out,
    input  logic                   po_reset_n,
    input  logic                   psel_i,
    input  logic                   penable_i,
    input  logic                   pwrite_i,
    input  logic [`OSC_ADDR_W-1:0] paddr_i,
    input  logic [`OSC_DATA_W-1:0] pwdata_i,
    input  logic [`OSC_BTN_W-1:0]  btn_i,
    input  logic                   resync_active_i,
    output logic [`OSC_DATA_W-1:0] prdata_o,
    output logic                   pready_o,
    output logic                   pslverr_o,
    output logic                   poweron_o,
    output logic                   capture_sel_o,
    output logic                   hsync_pol_o,
    output logic                   vsync_pol_o,
    output logic                   framelock_o
);

    logic [`OSC_CTRL_W-1:0] ctrl_q;
    logic [`OSC_BTN_W-1:0]  btn_sync1_q;
    logic [`OSC_BTN_W-1:0]  btn_sync2_q;
    logic [`OSC_DATA_W-1:0] status;
    logic                   access;
    logic                   hit_ctrl;
    logic                   hit_status;

    assign access     = psel_i & penable_i;
    assign hit_ctrl   = (paddr_i == osc_pkg::REG_CTRL);
    assign hit_status = (paddr_i == osc_pkg::REG_STATUS);

    // No wait states
    assign pready_o  = 1'b1;
    assign pslverr_o = access & ~(hit_ctrl | (hit_status & ~pwrite_i));

    always_ff @(posedge pclk_out or negedge po_reset_n) begin
        if (!po_reset_n) begin
            ctrl_q <= '0;
        end else if (access && pwrite_i && hit_ctrl) begin
            ctrl_q <= pwdata_i[`OSC_CTRL_W-1:0];
        end
    end

    // Buttons are active low, idle high
    always_ff @(posedge pclk_out or negedge po_reset_n) begin
        if (!po_reset_n) begin
            btn_sync1_q <= '1;
            btn_sync2_q <= '1;
        end else begin
            btn_sync1_q <= btn_i;
            btn_sync2_q <= btn_sync1_q;
        end
    end

    always_comb begin
        status = '0;
        status[`OSC_BTN_W-1:0] = btn_sync2_q;
        status[`OSC_STAT_RESYNC_BIT] = resync_active_i;
    end

    always_comb begin
        prdata_o = '0;
        if (access && !pwrite_i) begin
            if (hit_ctrl) begin
                prdata_o[`OSC_CTRL_W-1:0] = ctrl_q;
            end else if (hit_status) begin
                prdata_o = status;
            end
        end
    end

    assign poweron_o     = ctrl_q[osc_pkg::CTRL_POWERON];
    assign capture_sel_o = ctrl_q[osc_pkg::CTRL_CAPTURE_SEL];
    assign hsync_pol_o   = ctrl_q[osc_pkg::CTRL_HSYNC_POL];
    assign vsync_pol_o   = ctrl_q[osc_pkg::CTRL_VSYNC_POL];
    assign framelock_o   = ctrl_q[osc_pkg::CTRL_FRAMELOCK];

    // Access phase only inside a selected transfer
    a_penable_needs_psel: assert property (
        @(posedge pclk_out) disable iff (!po_reset_n)
        penable_i |-> psel_i
    );

endmodule

/* osc_tb.sv */
// ------------------------------------------------
// Testbench for the scan converter output path
// Random video on both sources, APB access, OSD, LED and buttons
// ------------------------------------------------
`timescale 1ns/1ps
`include "osc_defs.svh"

module osc_tb;

    localparam int CLK_NS     = 10;
    localparam int RST_CYCLES = 8;
    localparam int VID_CYCLES = 200;
    localparam int OSD_CYCLES = 30;
    localparam int LED_WAIT   = 4;
    localparam int R_LSB      = 3 + 2 * `OSC_PIX_W;
    localparam int G_LSB      = 3 + `OSC_PIX_W;
    localparam int B_LSB      = 3;
    // Reset, registers, video phases, OSD phases, LED and buttons
    localparam int RUN_CYCLES = RST_CYCLES + 60 + 4 * (VID_CYCLES + 10)
                              + 4 * (OSD_CYCLES + 10) + 4 * `OSC_RESYNC_LED_CYCLES + 80;
    localparam int WATCHDOG_NS = (RUN_CYCLES + 500) * CLK_NS;

    logic                   pclk_out;
    logic                   po_reset_n;
    logic                   psel;
    logic                   penable;
    logic                   pwrite;
    logic [`OSC_ADDR_W-1:0] paddr;
    logic [`OSC_DATA_W-1:0] pwdata;
    logic [`OSC_DATA_W-1:0] prdata;
    logic                   pready;
    logic                   pslverr;
    logic [`OSC_BTN_W-1:0]  btn;
    // Video packed as {r, g, b, hsync, vsync, de}
    logic [`OSC_VID_W-1:0]  ana_vid;
    logic [`OSC_VID_W-1:0]  hdmi_vid;
    logic [`OSC_VID_W-1:0]  tx_vid;
    logic                   osd_enable;
    osc_pkg::osd_color_e    osd_color;
    logic                   resync_strobe;
    logic [1:0]             led;

    logic [`OSC_VID_W-1:0]  ana_hist [0:7];
    logic [`OSC_VID_W-1:0]  hdmi_hist [0:7];
    logic                   osd_en_hist [0:7];
    logic [1:0]             osd_col_hist [0:7];
    logic [`OSC_CTRL_W-1:0] ctrl_model;
    logic                   check_en = 1'b0;
    string                  cur_test = "init";
    int                     value_errs = 0;
    int                     other_errs = 0;
    integer                 seed = 32'h594;

    osc_top dut_i (
        .pclk_out        (pclk_out),
        .po_reset_n      (po_reset_n),
        .psel_i          (psel),
        .penable_i       (penable),
        .pwrite_i        (pwrite),
        .paddr_i         (paddr),
        .pwdata_i        (pwdata),
        .prdata_o        (prdata),
        .pready_o        (pready),
        .pslverr_o       (pslverr),
        .btn_i           (btn),
        .ana_r_i         (ana_vid[R_LSB +: `OSC_PIX_W]),
        .ana_g_i         (ana_vid[G_LSB +: `OSC_PIX_W]),
        .ana_b_i         (ana_vid[B_LSB +: `OSC_PIX_W]),
        .ana_hsync_i     (ana_vid[2]),
        .ana_vsync_i     (ana_vid[1]),
        .ana_de_i        (ana_vid[0]),
        .hdmi_r_i        (hdmi_vid[R_LSB +: `OSC_PIX_W]),
        .hdmi_g_i        (hdmi_vid[G_LSB +: `OSC_PIX_W]),
        .hdmi_b_i        (hdmi_vid[B_LSB +: `OSC_PIX_W]),
        .hdmi_hsync_i    (hdmi_vid[2]),
        .hdmi_vsync_i    (hdmi_vid[1]),
        .hdmi_de_i       (hdmi_vid[0]),
        .osd_enable_i    (osd_enable),
        .osd_color_i     (osd_color),
        .resync_strobe_i (resync_strobe),
        .tx_r_o          (tx_vid[R_LSB +: `OSC_PIX_W]),
        .tx_g_o          (tx_vid[G_LSB +: `OSC_PIX_W]),
        .tx_b_o          (tx_vid[B_LSB +: `OSC_PIX_W]),
        .tx_hsync_o      (tx_vid[2]),
        .tx_vsync_o      (tx_vid[1]),
        .tx_de_o         (tx_vid[0]),
        .led_o           (led)
    );

    initial begin : clock_proc
        pclk_out = 1'b0;
        forever begin
            #(CLK_NS / 2);
            pclk_out = ~pclk_out;
        end
    end

    // Expected tx word from source select, sync polarity and OSD color
    function automatic logic [`OSC_VID_W-1:0] expected_tx(
            input logic [`OSC_VID_W-1:0] ana, input logic [`OSC_VID_W-1:0] hdmi,
            input logic [`OSC_CTRL_W-1:0] ctrl, input logic osd_en, input logic [1:0] osd_col);
        logic [`OSC_VID_W-1:0] vid;
        logic [23:0]           rgb;
        if (ctrl[osc_pkg::CTRL_CAPTURE_SEL]) begin
            vid = hdmi;
        end else begin
            vid = ana;
            vid[2] = ana[2] ^ ctrl[osc_pkg::CTRL_HSYNC_POL];
            vid[1] = ana[1] ^ ctrl[osc_pkg::CTRL_VSYNC_POL];
        end
        if (osd_en) begin
            case (osd_col)
                2'd0: rgb = `OSC_COLOR_BLACK;
                2'd1: rgb = `OSC_COLOR_BLUE;
                2'd2: rgb = `OSC_COLOR_YELLOW;
                default: rgb = `OSC_COLOR_WHITE;
            endcase
            vid[`OSC_VID_W-1:3] = rgb;
        end
        return vid;
    endfunction

    function automatic logic [`OSC_DATA_W-1:0] ctrl_word(input logic pwr, input logic sel,
            input logic hpol, input logic vpol, input logic lock);
        logic [`OSC_DATA_W-1:0] w;
        w = '0;
        w[osc_pkg::CTRL_POWERON]     = pwr;
        w[osc_pkg::CTRL_CAPTURE_SEL] = sel;
        w[osc_pkg::CTRL_HSYNC_POL]   = hpol;
        w[osc_pkg::CTRL_VSYNC_POL]   = vpol;
        w[osc_pkg::CTRL_FRAMELOCK]   = lock;
        return w;
    endfunction

    task automatic check_equal(input string what, input logic [31:0] exp,
            input logic [31:0] got);
        assert (exp === got) else begin
            $display("ERR %s %s: expected %h, actual %h", cur_test, what, exp, got);
            value_errs++;
        end
    endtask

    task automatic check_cond(input logic ok, input string msg);
        assert (ok) else begin
            $display("%s: %s", cur_test, msg);
            other_errs++;
        end
    endtask

    task automatic apb_write(input logic [`OSC_ADDR_W-1:0] addr,
            input logic [`OSC_DATA_W-1:0] data, output logic err);
        @(posedge pclk_out);
        #1;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(posedge pclk_out);
        #1;
        penable = 1'b1;
        @(negedge pclk_out);
        err = pslverr;
        check_cond(pready === 1'b1, "pready was not high in the write access phase");
        @(posedge pclk_out);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(input logic [`OSC_ADDR_W-1:0] addr,
            output logic [`OSC_DATA_W-1:0] data, output logic err);
        @(posedge pclk_out);
        #1;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        @(posedge pclk_out);
        #1;
        penable = 1'b1;
        @(negedge pclk_out);
        data = prdata;
        err  = pslverr;
        check_cond(pready === 1'b1, "pready was not high in the read access phase");
        @(posedge pclk_out);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    // Mixing cycles after a control change are skipped
    task automatic run_video(input string name, input logic [`OSC_DATA_W-1:0] ctrl,
            input int cycles);
        logic err;
        check_en = 1'b0;
        cur_test = name;
        apb_write(osc_pkg::REG_CTRL, ctrl, err);
        check_equal("ctrl write pslverr", 32'd0, 32'(err));
        ctrl_model = ctrl[`OSC_CTRL_W-1:0];
        repeat (3) @(posedge pclk_out);
        check_en = 1'b1;
        repeat (cycles) @(posedge pclk_out);
        check_en = 1'b0;
    endtask

    always @(posedge pclk_out) begin : video_drive_proc
        logic [31:0] rnd;
        #1;
        rnd = $random(seed);
        ana_vid = rnd[`OSC_VID_W-1:0];
        rnd = $random(seed);
        hdmi_vid = rnd[`OSC_VID_W-1:0];
    end

    // Input history and per-cycle comparison
    always @(negedge pclk_out) begin : compare_proc
        logic [`OSC_VID_W-1:0] exp;
        for (int i = 7; i > 0; i--) begin
            ana_hist[i]     = ana_hist[i-1];
            hdmi_hist[i]    = hdmi_hist[i-1];
            osd_en_hist[i]  = osd_en_hist[i-1];
            osd_col_hist[i] = osd_col_hist[i-1];
        end
        ana_hist[0]     = ana_vid;
        hdmi_hist[0]    = hdmi_vid;
        osd_en_hist[0]  = osd_enable;
        osd_col_hist[0] = osd_color;
        if (check_en) begin
            exp = expected_tx(ana_hist[4], hdmi_hist[5], ctrl_model,
                              osd_en_hist[2], osd_col_hist[2]);
            check_equal("tx video", 32'(exp), 32'(tx_vid));
        end
    end

    initial begin : main_proc
        logic                   err;
        logic [`OSC_DATA_W-1:0] rdata;
        logic [`OSC_BTN_W-1:0]  pattern;
        int                     n;
        time                    t_on;
        time                    t_off;
        po_reset_n    = 1'b0;
        psel          = 1'b0;
        penable       = 1'b0;
        pwrite        = 1'b0;
        paddr         = '0;
        pwdata        = '0;
        btn           = '1;
        ana_vid       = '0;
        hdmi_vid      = '0;
        osd_enable    = 1'b0;
        osd_color     = osc_pkg::OSD_BLACK;
        resync_strobe = 1'b0;
        ctrl_model    = '0;
        repeat (RST_CYCLES) @(posedge pclk_out);
        #1;
        po_reset_n = 1'b1;
        #1;
        cur_test = "reset";
        check_equal("tx video", 32'd0, 32'(tx_vid));

        cur_test = "registers";
        apb_write(osc_pkg::REG_CTRL, 32'h15, err);
        check_equal("write pslverr", 32'd0, 32'(err));
        apb_read(osc_pkg::REG_CTRL, rdata, err);
        check_equal("ctrl readback", 32'h15, rdata);
        apb_write(osc_pkg::REG_CTRL, 32'h0a, err);
        apb_read(osc_pkg::REG_CTRL, rdata, err);
        check_equal("ctrl readback", 32'h0a, rdata);
        apb_read(4'h8, rdata, err);
        check_equal("unused read pslverr", 32'd1, 32'(err));
        apb_write(osc_pkg::REG_STATUS, 32'h1f, err);
        check_equal("status write pslverr", 32'd1, 32'(err));
        apb_read(osc_pkg::REG_CTRL, rdata, err);
        check_equal("ctrl unchanged", 32'h0a, rdata);

        run_video("analog", ctrl_word(0, 0, 0, 0, 0), VID_CYCLES);
        run_video("analog hsync pol", ctrl_word(0, 0, 1, 0, 0), VID_CYCLES);
        run_video("analog both pol", ctrl_word(0, 0, 1, 1, 0), VID_CYCLES);
        run_video("hdmi", ctrl_word(0, 1, 1, 0, 0), VID_CYCLES);

        for (int c = 0; c < 4; c++) begin
            #1;
            osd_enable = 1'b1;
            osd_color  = osc_pkg::osd_color_e'(c);
            run_video($sformatf("osd color %0d", c), ctrl_word(0, 0, 0, 0, 0), OSD_CYCLES);
        end
        #1;
        osd_enable = 1'b0;

        cur_test = "resync led";
        apb_write(osc_pkg::REG_CTRL, ctrl_word(1, 0, 0, 0, 0), err);
        n = 0;
        @(negedge pclk_out);
        while (led[0] && n < 2 * `OSC_RESYNC_LED_CYCLES) begin
            @(negedge pclk_out);
            n++;
        end
        check_cond(!led[0], "LED stayed on after power on");
        @(posedge pclk_out);
        #1;
        resync_strobe = 1'b1;
        repeat (2) @(posedge pclk_out);
        #1;
        resync_strobe = 1'b0;
        n = 2;
        @(negedge pclk_out);
        while (!led[0] && n < 2 * LED_WAIT) begin
            @(negedge pclk_out);
            n++;
        end
        check_cond(led[0] && n <= LED_WAIT, "LED did not turn on within 4 cycles");
        t_on = $time;
        apb_read(osc_pkg::REG_STATUS, rdata, err);
        check_equal("status bit 8 while on", 32'd1, 32'(rdata[`OSC_STAT_RESYNC_BIT]));
        while (led[0] && ($time - t_on) < 2 * `OSC_RESYNC_LED_CYCLES * CLK_NS) begin
            @(negedge pclk_out);
        end
        t_off = $time;
        n = int'((t_off - t_on) / CLK_NS);
        check_cond(n >= `OSC_RESYNC_LED_CYCLES - 1 && n <= `OSC_RESYNC_LED_CYCLES + 1,
                   $sformatf("LED was on for %0d cycles, out of range", n));
        apb_read(osc_pkg::REG_STATUS, rdata, err);
        check_equal("status bit 8 after off", 32'd0, 32'(rdata[`OSC_STAT_RESYNC_BIT]));

        cur_test = "framelock led";
        for (int k = 0; k < 4; k++) begin
            apb_write(osc_pkg::REG_CTRL, ctrl_word(k[0], 0, 0, 0, k[1]), err);
            @(negedge pclk_out);
            check_equal("led_o[1]", 32'(k[0] & k[1]), 32'(led[1]));
        end

        cur_test = "buttons";
        for (int k = 0; k < 3; k++) begin
            pattern = (k == 0) ? 6'b101010 : ((k == 1) ? 6'b010101 : 6'b000000);
            @(posedge pclk_out);
            #1;
            btn = pattern;
            repeat (3) @(posedge pclk_out);
            apb_read(osc_pkg::REG_STATUS, rdata, err);
            check_equal("status buttons", 32'(pattern), 32'(rdata[`OSC_BTN_W-1:0]));
        end

        repeat (4) @(posedge pclk_out);
        $display("value errors: %0d, other errors: %0d", value_errs, other_errs);
        if (value_errs + other_errs == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    initial begin : watchdog_proc
        #(WATCHDOG_NS);
        $display("timeout: run did not finish within %0d ns", WATCHDOG_NS);
        $display("value errors: %0d, other errors: %0d", value_errs, other_errs);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

/* osc_top.sv */
// ------------------------------------------------
// Output path top level of the scan converter
// APB registers, capture, OSD overlay and resync LED
// ------------------------------------------------
`timescale 1ns/1ps
`include "osc_defs.svh"

module osc_top (
    input  logic                   pclk_out,
    input  logic                   po_reset_n,
    input  logic                   psel_i,
    input  logic                   penable_i,
    input  logic                   pwrite_i,
    input  logic [`OSC_ADDR_W-1:0] paddr_i,
    input  logic [`OSC_DATA_W-1:0] pwdata_i,
    output logic [`OSC_DATA_W-1:0] prdata_o,
    output logic                   pready_o,
    output logic                   pslverr_o,
    input  logic [`OSC_BTN_W-1:0]  btn_i,
    input  logic [`OSC_PIX_W-1:0]  ana_r_i,
    input  logic [`OSC_PIX_W-1:0]  ana_g_i,
    input  logic [`OSC_PIX_W-1:0]  ana_b_i,
    input  logic                   ana_hsync_i,
    input  logic                   ana_vsync_i,
    input  logic                   ana_de_i,
    input  logic [`OSC_PIX_W-1:0]  hdmi_r_i,
    input  logic [`OSC_PIX_W-1:0]  hdmi_g_i,
    input  logic [`OSC_PIX_W-1:0]  hdmi_b_i,
    input  logic                   hdmi_hsync_i,
    input  logic                   hdmi_vsync_i,
    input  logic                   hdmi_de_i,
    input  logic                   osd_enable_i,
    input  osc_pkg::osd_color_e    osd_color_i,
    input  logic                   resync_strobe_i,
    output logic [`OSC_PIX_W-1:0]  tx_r_o,
    output logic [`OSC_PIX_W-1:0]  tx_g_o,
    output logic [`OSC_PIX_W-1:0]  tx_b_o,
    output logic                   tx_hsync_o,
    output logic                   tx_vsync_o,
    output logic                   tx_de_o,
    output logic [1:0]             led_o
);

    logic                  poweron;
    logic                  capture_sel;
    logic                  hsync_pol;
    logic                  vsync_pol;
    logic                  framelock;
    logic                  resync_active;
    logic [`OSC_PIX_W-1:0] cap_r;
    logic [`OSC_PIX_W-1:0] cap_g;
    logic [`OSC_PIX_W-1:0] cap_b;
    logic                  cap_hsync;
    logic                  cap_vsync;
    logic                  cap_de;

    osc_sys_regs u_sys_regs (
        .pclk_out        (pclk_out),
        .po_reset_n      (po_reset_n),
        .psel_i          (psel_i),
        .penable_i       (penable_i),
        .pwrite_i        (pwrite_i),
        .paddr_i         (paddr_i),
        .pwdata_i        (pwdata_i),
        .btn_i           (btn_i),
        .resync_active_i (resync_active),
        .prdata_o        (prdata_o),
        .pready_o        (pready_o),
        .pslverr_o       (pslverr_o),
        .poweron_o       (poweron),
        .capture_sel_o   (capture_sel),
        .hsync_pol_o     (hsync_pol),
        .vsync_pol_o     (vsync_pol),
        .framelock_o     (framelock)
    );

    osc_capture_mux u_capture (
        .pclk_out      (pclk_out),
        .po_reset_n    (po_reset_n),
        .capture_sel_i (capture_sel),
        .hsync_pol_i   (hsync_pol),
        .vsync_pol_i   (vsync_pol),
        .ana_r_i       (ana_r_i),
        .ana_g_i       (ana_g_i),
        .ana_b_i       (ana_b_i),
        .ana_hsync_i   (ana_hsync_i),
        .ana_vsync_i   (ana_vsync_i),
        .ana_de_i      (ana_de_i),
        .hdmi_r_i      (hdmi_r_i),
        .hdmi_g_i      (hdmi_g_i),
        .hdmi_b_i      (hdmi_b_i),
        .hdmi_hsync_i  (hdmi_hsync_i),
        .hdmi_vsync_i  (hdmi_vsync_i),
        .hdmi_de_i     (hdmi_de_i),
        .cap_r_o       (cap_r),
        .cap_g_o       (cap_g),
        .cap_b_o       (cap_b),
        .cap_hsync_o   (cap_hsync),
        .cap_vsync_o   (cap_vsync),
        .cap_de_o      (cap_de)
    );

    osc_osd_overlay u_overlay (
        .pclk_out     (pclk_out),
        .po_reset_n   (po_reset_n),
        .r_i          (cap_r),
        .g_i          (cap_g),
        .b_i          (cap_b),
        .hsync_i      (cap_hsync),
        .vsync_i      (cap_vsync),
        .de_i         (cap_de),
        .osd_enable_i (osd_enable_i),
        .osd_color_i  (osd_color_i),
        .tx_r_o       (tx_r_o),
        .tx_g_o       (tx_g_o),
        .tx_b_o       (tx_b_o),
        .tx_hsync_o   (tx_hsync_o),
        .tx_vsync_o   (tx_vsync_o),
        .tx_de_o      (tx_de_o)
    );

    osc_resync_led u_resync_led (
        .pclk_out        (pclk_out),
        .po_reset_n      (po_reset_n),
        .resync_strobe_i (resync_strobe_i),
        .poweron_i       (poweron),
        .framelock_i     (framelock),
        .led_o           (led_o),
        .resync_active_o (resync_active)
    );

endmodule

/* run.sh */
#!/usr/bin/env bash
# Build and run the output path testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f build.f --top-module osc_tb -o osc_sim

./obj_dir/osc_sim > sim.log
cat sim.log

if grep -q "^NO ERRORS$" sim.log; then
    echo "simulation passed"
    exit 0
fi

echo "simulation failed"
exit 1
